/* rtl/cpustatreg_settings.svh */
`ifndef CPUSTATREG_SETTINGS_SVH
`define CPUSTATREG_SETTINGS_SVH

// APB window is 4 KB
`define CPUSTATREG_ADDR_W 12

// PC out of reset
`define CPUSTATREG_RESET_PC 64'h0000_0000_8000_0000

// Low word offsets, high word sits at +4
`define CPUSTATREG_PC  12'h000
`define CPUSTATREG_X1  12'h008
`define CPUSTATREG_X2  12'h010
`define CPUSTATREG_X3  12'h018
`define CPUSTATREG_X4  12'h020
`define CPUSTATREG_X5  12'h028
`define CPUSTATREG_X6  12'h030
`define CPUSTATREG_X7  12'h038
`define CPUSTATREG_X8  12'h040
`define CPUSTATREG_X9  12'h048
`define CPUSTATREG_X10 12'h050
`define CPUSTATREG_X11 12'h058
`define CPUSTATREG_X12 12'h060
`define CPUSTATREG_X13 12'h068
`define CPUSTATREG_X14 12'h070
`define CPUSTATREG_X15 12'h078
`define CPUSTATREG_X16 12'h080
`define CPUSTATREG_X17 12'h088
`define CPUSTATREG_X18 12'h090
`define CPUSTATREG_X19 12'h098
`define CPUSTATREG_X20 12'h0A0
`define CPUSTATREG_X21 12'h0A8
`define CPUSTATREG_X22 12'h0B0
`define CPUSTATREG_X23 12'h0B8
`define CPUSTATREG_X24 12'h0C0
`define CPUSTATREG_X25 12'h0C8
`define CPUSTATREG_X26 12'h0D0
`define CPUSTATREG_X27 12'h0D8
`define CPUSTATREG_X28 12'h0E0
`define CPUSTATREG_X29 12'h0E8
`define CPUSTATREG_X30 12'h0F0
`define CPUSTATREG_X31 12'h0F8

`endif

/* rtl/cpu_dbg_pkg.sv */
package cpu_dbg_pkg;

// Retired instruction kinds reported on the commit port
typedef enum logic [1:0] {
    COMMIT_NOP    = 2'd0,  // PC + 4, no register write
    COMMIT_ALU    = 2'd1,  // PC + 4, rd <= commit_data
    COMMIT_JUMP   = 2'd2,  // rd <= PC + 4, PC <= target
    COMMIT_BRANCH = 2'd3   // PC <= target
} commit_op_e;

// RV64 register and PC value
typedef logic [63:0] xlen_t;

// Register index x0..x31
typedef logic [4:0] reg_idx_t;

endpackage

/* rtl/apb_if.sv */
`timescale 1ns/1ps
`include "cpustatreg_settings.svh"

interface apb_if;

logic                           psel;
logic                           penable;
logic                           pwrite;
logic [`CPUSTATREG_ADDR_W-1:0]  paddr;
logic [31:0]                    pwdata;
logic [31:0]                    prdata;
logic                           pready;
logic                           pslverr;

modport master (
    output psel, penable, pwrite, paddr, pwdata,
    input  prdata, pready, pslverr
);

modport slave (
    input  psel, penable, pwrite, paddr, pwdata,
    output prdata, pready, pslverr
);

endinterface

/* rtl/arch_state.sv */
`timescale 1ns/1ps
`include "cpustatreg_settings.svh"

module arch_state (
    input  logic                    clk,
    input  logic                    rstn,

    input  logic                    commit_valid,
    input  cpu_dbg_pkg::commit_op_e commit_op,
    input  cpu_dbg_pkg::reg_idx_t   commit_rd,
    input  cpu_dbg_pkg::xlen_t      commit_data,
    input  cpu_dbg_pkg::xlen_t      commit_target,

    output cpu_dbg_pkg::xlen_t      pc,
    output cpu_dbg_pkg::xlen_t      gpr [32]
);

cpu_dbg_pkg::xlen_t pc_q;
cpu_dbg_pkg::xlen_t x_q [1:31];   // x0 has no storage
cpu_dbg_pkg::xlen_t pc_plus4;
cpu_dbg_pkg::xlen_t pc_next;
cpu_dbg_pkg::xlen_t rd_data;
logic               rd_we;

assign pc_plus4 = pc_q + 64'd4;

always_comb begin: comb_next
    pc_next = pc_plus4;
    rd_data = commit_data;
    rd_we   = 1'b0;
    case (commit_op)
        cpu_dbg_pkg::COMMIT_ALU: begin
            rd_we = 1'b1;
        end
        cpu_dbg_pkg::COMMIT_JUMP: begin
            rd_we   = 1'b1;
            rd_data = pc_plus4;     // Link address
            pc_next = commit_target;
        end
        cpu_dbg_pkg::COMMIT_BRANCH: begin
            pc_next = commit_target;
        end
        default: begin
            pc_next = pc_plus4;     // NOP
        end
    endcase
    // Writes to x0 are dropped
    rd_we = rd_we & commit_valid & (commit_rd != 5'd0);
end

always_ff @(posedge clk or negedge rstn) begin: reg_state
    if (~rstn) begin
        pc_q <= `CPUSTATREG_RESET_PC;
        for (int i = 1; i < 32; i++) begin
            x_q[i] <= '0;
        end
    end
    else begin
        if (commit_valid) pc_q <= pc_next;
        if (rd_we) x_q[commit_rd] <= rd_data;
    end
end

always_comb begin: comb_gpr
    gpr[0] = '0;    // Hardwired zero
    for (int i = 1; i < 32; i++) begin
        gpr[i] = x_q[i];
    end
end

assign pc = pc_q;

endmodule

/* rtl/cpustatreg.sv */
`timescale 1ns/1ps
`include "cpustatreg_settings.svh"

module cpustatreg (
    input  logic               clk,
    input  logic               rstn,
    apb_if.slave               apb,

    input  cpu_dbg_pkg::xlen_t pc,
    input  cpu_dbg_pkg::xlen_t gpr [32]
);

logic [31:0] rd_word;

// Word select from the low address bits, unmapped offsets give zero
always_comb begin: comb_rd_word
    rd_word = 32'b0;
    case (apb.paddr[11:0])
        `CPUSTATREG_PC  + 12'd0: rd_word = pc[31:0];
        `CPUSTATREG_PC  + 12'd4: rd_word = pc[63:32];
        `CPUSTATREG_X1  + 12'd0: rd_word = gpr[1][31:0];
        `CPUSTATREG_X1  + 12'd4: rd_word = gpr[1][63:32];
        `CPUSTATREG_X2  + 12'd0: rd_word = gpr[2][31:0];
        `CPUSTATREG_X2  + 12'd4: rd_word = gpr[2][63:32];
        `CPUSTATREG_X3  + 12'd0: rd_word = gpr[3][31:0];
        `CPUSTATREG_X3  + 12'd4: rd_word = gpr[3][63:32];
        `CPUSTATREG_X4  + 12'd0: rd_word = gpr[4][31:0];
        `CPUSTATREG_X4  + 12'd4: rd_word = gpr[4][63:32];
        `CPUSTATREG_X5  + 12'd0: rd_word = gpr[5][31:0];
        `CPUSTATREG_X5  + 12'd4: rd_word = gpr[5][63:32];
        `CPUSTATREG_X6  + 12'd0: rd_word = gpr[6][31:0];
        `CPUSTATREG_X6  + 12'd4: rd_word = gpr[6][63:32];
        `CPUSTATREG_X7  + 12'd0: rd_word = gpr[7][31:0];
        `CPUSTATREG_X7  + 12'd4: rd_word = gpr[7][63:32];
        `CPUSTATREG_X8  + 12'd0: rd_word = gpr[8][31:0];
        `CPUSTATREG_X8  + 12'd4: rd_word = gpr[8][63:32];
        `CPUSTATREG_X9  + 12'd0: rd_word = gpr[9][31:0];
        `CPUSTATREG_X9  + 12'd4: rd_word = gpr[9][63:32];
        `CPUSTATREG_X10 + 12'd0: rd_word = gpr[10][31:0];
        `CPUSTATREG_X10 + 12'd4: rd_word = gpr[10][63:32];
        `CPUSTATREG_X11 + 12'd0: rd_word = gpr[11][31:0];
        `CPUSTATREG_X11 + 12'd4: rd_word = gpr[11][63:32];
        `CPUSTATREG_X12 + 12'd0: rd_word = gpr[12][31:0];
        `CPUSTATREG_X12 + 12'd4: rd_word = gpr[12][63:32];
        `CPUSTATREG_X13 + 12'd0: rd_word = gpr[13][31:0];
        `CPUSTATREG_X13 + 12'd4: rd_word = gpr[13][63:32];
        `CPUSTATREG_X14 + 12'd0: rd_word = gpr[14][31:0];
        `CPUSTATREG_X14 + 12'd4: rd_word = gpr[14][63:32];
        `CPUSTATREG_X15 + 12'd0: rd_word = gpr[15][31:0];
        `CPUSTATREG_X15 + 12'd4: rd_word = gpr[15][63:32];
        `CPUSTATREG_X16 + 12'd0: rd_word = gpr[16][31:0];
        `CPUSTATREG_X16 + 12'd4: rd_word = gpr[16][63:32];
        `CPUSTATREG_X17 + 12'd0: rd_word = gpr[17][31:0];
        `CPUSTATREG_X17 + 12'd4: rd_word = gpr[17][63:32];
        `CPUSTATREG_X18 + 12'd0: rd_word = gpr[18][31:0];
        `CPUSTATREG_X18 + 12'd4: rd_word = gpr[18][63:32];
        `CPUSTATREG_X19 + 12'd0: rd_word = gpr[19][31:0];
        `CPUSTATREG_X19 + 12'd4: rd_word = gpr[19][63:32];
        `CPUSTATREG_X20 + 12'd0: rd_word = gpr[20][31:0];
        `CPUSTATREG_X20 + 12'd4: rd_word = gpr[20][63:32];
        `CPUSTATREG_X21 + 12'd0: rd_word = gpr[21][31:0];
        `CPUSTATREG_X21 + 12'd4: rd_word = gpr[21][63:32];
        `CPUSTATREG_X22 + 12'd0: rd_word = gpr[22][31:0];
        `CPUSTATREG_X22 + 12'd4: rd_word = gpr[22][63:32];
        `CPUSTATREG_X23 + 12'd0: rd_word = gpr[23][31:0];
        `CPUSTATREG_X23 + 12'd4: rd_word = gpr[23][63:32];
        `CPUSTATREG_X24 + 12'd0: rd_word = gpr[24][31:0];
        `CPUSTATREG_X24 + 12'd4: rd_word = gpr[24][63:32];
        `CPUSTATREG_X25 + 12'd0: rd_word = gpr[25][31:0];
        `CPUSTATREG_X25 + 12'd4: rd_word = gpr[25][63:32];
        `CPUSTATREG_X26 + 12'd0: rd_word = gpr[26][31:0];
        `CPUSTATREG_X26 + 12'd4: rd_word = gpr[26][63:32];
        `CPUSTATREG_X27 + 12'd0: rd_word = gpr[27][31:0];
        `CPUSTATREG_X27 + 12'd4: rd_word = gpr[27][63:32];
        `CPUSTATREG_X28 + 12'd0: rd_word = gpr[28][31:0];
        `CPUSTATREG_X28 + 12'd4: rd_word = gpr[28][63:32];
        `CPUSTATREG_X29 + 12'd0: rd_word = gpr[29][31:0];
        `CPUSTATREG_X29 + 12'd4: rd_word = gpr[29][63:32];
        `CPUSTATREG_X30 + 12'd0: rd_word = gpr[30][31:0];
        `CPUSTATREG_X30 + 12'd4: rd_word = gpr[30][63:32];
        `CPUSTATREG_X31 + 12'd0: rd_word = gpr[31][31:0];
        `CPUSTATREG_X31 + 12'd4: rd_word = gpr[31][63:32];
        default:                 rd_word = 32'b0;
    endcase
end

// Sampled every edge, so data is ready by the access cycle
always_ff @(posedge clk or negedge rstn) begin: reg_prdata
    if (~rstn) begin
        apb.prdata <= 32'b0;
    end
    else begin
        apb.prdata <= rd_word;
    end
end

// Zero wait states, writes have no target
assign apb.pready  = 1'b1;
assign apb.pslverr = 1'b0;

endmodule

/* rtl/cpu_status_top.sv */
`timescale 1ns/1ps

module cpu_status_top (
    input  logic                    clk,
    input  logic                    rstn,

    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [11:0]             paddr,
    input  logic [31:0]             pwdata,
    output logic [31:0]             prdata,
    output logic                    pready,
    output logic                    pslverr,

    input  logic                    commit_valid,
    input  cpu_dbg_pkg::commit_op_e commit_op,
    input  cpu_dbg_pkg::reg_idx_t   commit_rd,
    input  cpu_dbg_pkg::xlen_t      commit_data,
    input  cpu_dbg_pkg::xlen_t      commit_target
);

cpu_dbg_pkg::xlen_t pc;
cpu_dbg_pkg::xlen_t gpr [32];

apb_if u_apb ();

// External APB master side
assign u_apb.psel    = psel;
assign u_apb.penable = penable;
assign u_apb.pwrite  = pwrite;
assign u_apb.paddr   = paddr;
assign u_apb.pwdata  = pwdata;
assign prdata        = u_apb.prdata;
assign pready        = u_apb.pready;
assign pslverr       = u_apb.pslverr;

arch_state u_arch_state (
    .clk           (clk),
    .rstn          (rstn),
    .commit_valid  (commit_valid),
    .commit_op     (commit_op),
    .commit_rd     (commit_rd),
    .commit_data   (commit_data),
    .commit_target (commit_target),
    .pc            (pc),
    .gpr           (gpr)
);

cpustatreg u_cpustatreg (
    .clk  (clk),
    .rstn (rstn),
    .apb  (u_apb),
    .pc   (pc),
    .gpr  (gpr)
);

endmodule

/* verif/cpu_status_props.sv */
`timescale 1ns/1ps

module cpu_status_props (
    input logic        clk,
    input logic        rstn,
    input logic        psel,
    input logic        penable,
    input logic [11:0] paddr,
    input logic [31:0] prdata,
    input logic        pready,
    input logic        pslverr
);

// Slave never stalls and never flags an error
resp_always_ok: assert property (@(posedge clk) rstn |-> (pready && !pslverr))
    else $error("pready low or pslverr high while out of reset");

// No access phase without a setup phase right before it
access_after_setup: assert property (@(posedge clk) disable iff (!rstn)
    (psel && penable) |-> $past(psel && !penable))
    else $error("access cycle without a preceding setup cycle");

// Offsets past x31 high word read as zero
unmapped_reads_zero: assert property (@(posedge clk) disable iff (!rstn)
    (psel && !penable && paddr > 12'h0FC) |=> (prdata == 32'b0))
    else $error("nonzero prdata for an unmapped offset");

endmodule

bind cpu_status_top cpu_status_props u_props (
    .clk     (clk),
    .rstn    (rstn),
    .psel    (psel),
    .penable (penable),
    .paddr   (paddr),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
);

/* verif/cpu_status_tb.sv */
`timescale 1ns/1ps
`include "cpustatreg_settings.svh"

module cpu_status_tb;

logic                    clk;
logic                    rstn;
logic                    psel;
logic                    penable;
logic                    pwrite;
logic [11:0]             paddr;
logic [31:0]             pwdata;
logic [31:0]             prdata;
logic                    pready;
logic                    pslverr;
logic                    commit_valid;
cpu_dbg_pkg::commit_op_e commit_op;
cpu_dbg_pkg::reg_idx_t   commit_rd;
cpu_dbg_pkg::xlen_t      commit_data;
cpu_dbg_pkg::xlen_t      commit_target;

cpu_dbg_pkg::xlen_t      model_pc;
cpu_dbg_pkg::xlen_t      model_gpr [32];   // Entry 0 stays zero
int                      errors;
int                      checks;

cpu_status_top u_dut (.*);

initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
end

task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
        errors++;
        $display("error %s: expected %h, actual %h", name, exp, act);
    end
endtask

// Word the map should return for an offset, taken from the model
function automatic logic [31:0] expected_word(input logic [11:0] addr);
    cpu_dbg_pkg::xlen_t val;
    if (addr[1:0] != 2'b00 || addr > 12'h0FC) return 32'b0;
    if (addr[11:3] == 9'd0) val = model_pc;
    else val = model_gpr[addr[7:3]];
    return addr[2] ? val[63:32] : val[31:0];
endfunction

task automatic apb_transfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                            input bit chain, output logic [31:0] rdata, output logic slverr);
    int waited;
    @(negedge clk);
    psel    = 1'b1;   // Setup
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;   // Access
    waited  = 0;
    while (pready !== 1'b1 && waited < 10) begin
        @(negedge clk);
        waited++;
    end
    if (pready !== 1'b1) begin
        $display("timeout: pready stayed low for 10 cycles at offset %h", addr);
        $display("*** TEST FAILED ***");
        $finish;
    end
    else begin
        rdata  = prdata;
        slverr = pslverr;
        if (!chain) begin
            @(negedge clk);
            psel    = 1'b0;
            penable = 1'b0;
            pwrite  = 1'b0;
        end
    end
endtask

task automatic apb_read(input logic [11:0] addr, input bit chain, output logic [31:0] rdata);
    logic slverr;
    apb_transfer(1'b0, addr, 32'b0, chain, rdata, slverr);
endtask

task automatic apb_write(input logic [11:0] addr, input logic [31:0] wdata, output logic slverr);
    logic [31:0] rdata;
    apb_transfer(1'b1, addr, wdata, 1'b0, rdata, slverr);
endtask

task automatic read_expect(input string name, input logic [11:0] addr,
                           input logic [31:0] exp, input bit chain);
    logic [31:0] act;
    apb_read(addr, chain, act);
    check_word(name, exp, act);
endtask

task automatic read_check(input string name, input logic [11:0] addr, input bit chain);
    read_expect(name, addr, expected_word(addr), chain);
endtask

task automatic read_all(input string name);
    for (int i = 0; i < 64; i++) begin
        read_check(name, 12'(4 * i), 1'b0);
    end
endtask

// One retired instruction, model updated by the opcode rules
task automatic commit(input cpu_dbg_pkg::commit_op_e op, input cpu_dbg_pkg::reg_idx_t rd,
                      input cpu_dbg_pkg::xlen_t data, input cpu_dbg_pkg::xlen_t target);
    cpu_dbg_pkg::xlen_t link;
    link = model_pc + 64'd4;
    @(negedge clk);
    commit_valid  = 1'b1;
    commit_op     = op;
    commit_rd     = rd;
    commit_data   = data;
    commit_target = target;
    case (op)
        cpu_dbg_pkg::COMMIT_ALU: begin
            if (rd != 5'd0) model_gpr[rd] = data;
            model_pc = link;
        end
        cpu_dbg_pkg::COMMIT_JUMP: begin
            if (rd != 5'd0) model_gpr[rd] = link;
            model_pc = target;
        end
        cpu_dbg_pkg::COMMIT_BRANCH: model_pc = target;
        default: model_pc = link;
    endcase
    @(negedge clk);
    commit_valid = 1'b0;
endtask

task automatic test_reset_values();
    cpu_dbg_pkg::xlen_t rst_pc;
    rst_pc = `CPUSTATREG_RESET_PC;
    read_expect("test_reset_values", `CPUSTATREG_PC, rst_pc[31:0], 1'b0);
    read_expect("test_reset_values", `CPUSTATREG_PC + 12'd4, rst_pc[63:32], 1'b0);
    for (int i = 2; i < 64; i++) begin
        read_expect("test_reset_values", 12'(4 * i), 32'b0, 1'b0);
    end
endtask

task automatic test_alu_commits();
    cpu_dbg_pkg::xlen_t exp_pc;
    logic [11:0]        addr;
    for (int i = 1; i < 32; i++) begin
        addr = 12'(8 * i);
        commit(cpu_dbg_pkg::COMMIT_ALU, 5'(i), {$urandom, $urandom}, 64'b0);
        read_check("test_alu_commits", addr, 1'b0);
        read_check("test_alu_commits", addr + 12'd4, 1'b0);
    end
    exp_pc = `CPUSTATREG_RESET_PC + 64'd124;
    read_expect("test_alu_commits", `CPUSTATREG_PC, exp_pc[31:0], 1'b0);
    read_expect("test_alu_commits", `CPUSTATREG_PC + 12'd4, exp_pc[63:32], 1'b0);
endtask

task automatic test_x0_ignored();
    cpu_dbg_pkg::xlen_t exp_pc;
    exp_pc = model_pc + 64'd4;
    commit(cpu_dbg_pkg::COMMIT_ALU, 5'd0, {$urandom, $urandom}, 64'b0);
    read_all("test_x0_ignored");
    read_expect("test_x0_ignored", `CPUSTATREG_PC, exp_pc[31:0], 1'b0);
    read_expect("test_x0_ignored", `CPUSTATREG_PC + 12'd4, exp_pc[63:32], 1'b0);
    read_expect("test_x0_ignored", 12'h100, 32'b0, 1'b0);
    read_expect("test_x0_ignored", 12'hFFC, 32'b0, 1'b0);
    for (int i = 0; i < 8; i++) begin
        read_expect("test_x0_ignored", 12'(12'h104 + 12'h1F4 * i), 32'b0, 1'b0);
    end
endtask

task automatic test_jump_branch();
    cpu_dbg_pkg::xlen_t link;
    cpu_dbg_pkg::xlen_t target;
    link   = model_pc + 64'd4;
    target = 64'h0000_0000_8000_1000;
    commit(cpu_dbg_pkg::COMMIT_JUMP, 5'd5, {$urandom, $urandom}, target);
    read_expect("test_jump_branch", `CPUSTATREG_X5, link[31:0], 1'b0);
    read_expect("test_jump_branch", `CPUSTATREG_X5 + 12'd4, link[63:32], 1'b0);
    read_expect("test_jump_branch", `CPUSTATREG_PC, target[31:0], 1'b0);
    target = 64'h0000_0001_2345_6788;
    commit(cpu_dbg_pkg::COMMIT_BRANCH, 5'd7, {$urandom, $urandom}, target);
    read_all("test_jump_branch");        // x7 must be untouched
    read_expect("test_jump_branch", `CPUSTATREG_PC + 12'd4, 32'h0000_0001, 1'b0);
    commit(cpu_dbg_pkg::COMMIT_NOP, 5'd9, {$urandom, $urandom}, 64'h40);
    read_expect("test_jump_branch", `CPUSTATREG_PC, 32'h2345_678C, 1'b0);
    read_all("test_jump_branch");
endtask

task automatic test_write_ignored();
    logic slverr;
    logic [11:0] offs [4];
    offs = '{`CPUSTATREG_PC, `CPUSTATREG_PC + 12'd4, `CPUSTATREG_X3, `CPUSTATREG_X31 + 12'd4};
    foreach (offs[i]) begin
        apb_write(offs[i], $urandom, slverr);
        check_word("test_write_ignored", 32'b0, {31'b0, slverr});
        read_check("test_write_ignored", offs[i], 1'b0);
    end
endtask

task automatic test_back_to_back_reads();
    logic [11:0] seq [8];
    seq = '{12'h000, 12'h0F8, 12'h004, 12'h010, 12'h100, 12'h014, 12'h0FC, 12'h028};
    foreach (seq[i]) begin
        read_check("test_back_to_back_reads", seq[i], i != 7);
    end
endtask

initial begin
    rstn          = 1'b0;
    psel          = 1'b0;
    penable       = 1'b0;
    pwrite        = 1'b0;
    paddr         = 12'b0;
    pwdata        = 32'b0;
    commit_valid  = 1'b0;
    commit_op     = cpu_dbg_pkg::COMMIT_NOP;
    commit_rd     = 5'd0;
    commit_data   = 64'b0;
    commit_target = 64'b0;
    errors        = 0;
    checks        = 0;
    model_pc      = `CPUSTATREG_RESET_PC;
    foreach (model_gpr[i]) model_gpr[i] = 64'b0;
    void'($urandom(98424));
    repeat (4) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;

    test_reset_values();
    test_alu_commits();
    test_x0_ignored();
    test_jump_branch();
    test_write_ignored();
    test_back_to_back_reads();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
        $display("*** TEST PASSED ***");
    end
    else begin
        $display("*** TEST FAILED ***");
    end
    $finish;
end

endmodule

/* src.f */
+incdir+rtl
rtl/cpu_dbg_pkg.sv
rtl/apb_if.sv
rtl/arch_state.sv
rtl/cpustatreg.sv
rtl/cpu_status_top.sv
verif/cpu_status_props.sv
verif/cpu_status_tb.sv

/* Makefile */
TOP := cpu_status_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -qF "*** TEST PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log
